/* Bender.yml */
package:
  name: chroni

sources:
  - common/chroni_pkg.sv
  - hdl/chroni_regs.sv
  - hdl/palette_lut.sv
  - hdl/line_buffer.sv
  - video_timing/video_timing.sv
  - char_gen/char_gen.sv
  - hdl/chroni.sv
  - target: test
    files:
      - verif/chroni_props.sv
      - verif/chroni_tb.sv

/* build.f */
common/chroni_pkg.sv
hdl/chroni_regs.sv
hdl/palette_lut.sv
hdl/line_buffer.sv
video_timing/video_timing.sv
char_gen/char_gen.sv
hdl/chroni.sv
verif/chroni_props.sv
verif/chroni_tb.sv

/* char_gen/char_gen.sv */
`timescale 1ns/1ps

module char_gen (
   input  logic                              sys_clk,
   input  logic                              reset,
   input  logic                              frame_start,
   input  logic                              render_start,
   input  logic [5:0]                        render_line,
   input  logic                              render_bank,
   input  logic [7:0]                        fg_index,
   input  logic [7:0]                        bg_index,
   output logic [chroni_pkg::mem_addr_w-1:0] mem_addr,
   output logic                              mem_rd_req,
   input  logic                              mem_rd_ack,
   input  logic [7:0]                        mem_data,
   output chroni_pkg::glyph_wr_t             glyph_wr,
   input  logic                              wr_busy
);
   import chroni_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_text_read,
      st_text_wait,
      st_font_read,
      st_font_wait,
      st_glyph_write,
      st_done
   } cg_state_t;

   cg_state_t  state;
   logic [3:0] col;
   logic [2:0] scan;
   logic [1:0] row;
   logic       bank;
   logic [7:0] line_fg;
   logic [7:0] line_bg;
   logic [7:0] font_byte;
   logic [7:0] glyph_bits;
   logic [7:0] glyph_base;
   logic       glyph_en;
   logic [7:0] text_store [text_cols];

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state      <= st_idle;
         col        <= '0;
         mem_rd_req <= 1'b0;
         glyph_en   <= 1'b0;
      end else begin
         glyph_en <= 1'b0;
         if (render_start) begin
            col        <= '0;
            mem_rd_req <= 1'b0;
            // Codes are fetched only on the first scan row of a text row.
            state <= (render_line[2:0] == 3'd0) ? st_text_read : st_font_read;
         end else if (frame_start) begin
            mem_rd_req <= 1'b0;
            state      <= st_idle;
         end else begin
            case (state)
               st_text_read: begin
                  mem_rd_req <= 1'b1;
                  state      <= st_text_wait;
               end
               st_text_wait: begin
                  if (mem_rd_ack) begin
                     mem_rd_req <= 1'b0;
                     col        <= col + 4'd1;
                     state <= (col == 4'(text_cols - 1)) ? st_font_read : st_text_read;
                  end
               end
               st_font_read: begin
                  mem_rd_req <= 1'b1;
                  state      <= st_font_wait;
               end
               st_font_wait: begin
                  if (mem_rd_ack) begin
                     mem_rd_req <= 1'b0;
                     state      <= st_glyph_write;
                  end
               end
               st_glyph_write: begin
                  if (!wr_busy) begin
                     glyph_en <= 1'b1;
                     if (col == 4'(text_cols - 1)) begin
                        state <= st_done;
                     end else begin
                        col   <= col + 4'd1;
                        state <= st_font_read;
                     end
                  end
               end
               st_done: state <= st_idle;
               default: state <= st_idle;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (render_start) begin
         scan    <= render_line[2:0];
         row     <= render_line[4:3];
         bank    <= render_bank;
         line_fg <= fg_index;
         line_bg <= bg_index;
      end
      case (state)
         st_text_read: mem_addr <= text_base + mem_addr_w'({row, col});
         st_text_wait: if (mem_rd_ack) text_store[col] <= mem_data;
         st_font_read: mem_addr <= font_base + mem_addr_w'({text_store[col], scan});
         st_font_wait: if (mem_rd_ack) font_byte <= mem_data;
         st_glyph_write: begin
            glyph_bits <= font_byte;
            glyph_base <= {col, 3'b000};
         end
         default: ;
      endcase
   end

   assign glyph_wr = '{en: glyph_en, bank: bank, col_base: glyph_base,
                       bits: glyph_bits, fg: line_fg, bg: line_bg};

endmodule

/* common/chroni_pkg.sv */
package chroni_pkg;

   // Text geometry.
   localparam int text_cols = 16;
   localparam int text_rows = 4;
   localparam int glyph_h   = 8;

   // Horizontal timing in sys_clk cycles.
   localparam int h_active = 128;
   localparam int h_total  = 640;
   localparam int hs_start = 200;
   localparam int hs_len   = 64;

   // Vertical timing in lines.
   localparam int v_active = 32;
   localparam int v_total  = 40;
   localparam int vs_start = 34;
   localparam int vs_len   = 2;

   // Memory layout.
   localparam int mem_addr_w = 13;
   localparam logic [mem_addr_w-1:0] text_base = 13'h1e00;
   localparam logic [mem_addr_w-1:0] font_base = 13'h0000;

   // CPU register map.
   localparam logic [3:0] reg_fg        = 4'd0;
   localparam logic [3:0] reg_bg        = 4'd1;
   localparam logic [3:0] reg_pal_index = 4'd2;
   localparam logic [3:0] reg_pal_data  = 4'd3;

   typedef struct packed {
      logic       en;
      logic [3:0] addr;
      logic [7:0] data;
   } reg_wr_t;

   typedef struct packed {
      logic        en;
      logic [7:0]  index;
      logic [15:0] colour;
   } pal_wr_t;

   typedef struct packed {
      logic       en;
      logic       bank;
      logic [7:0] col_base;
      logic [7:0] bits;
      logic [7:0] fg;
      logic [7:0] bg;
   } glyph_wr_t;

   typedef struct packed {
      logic hs;
      logic vs;
      logic de;
   } video_sync_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

endpackage

/* hdl/chroni.sv */
`timescale 1ns/1ps

module chroni (
   input  logic                              sys_clk,
   input  logic                              reset,
   input  chroni_pkg::reg_wr_t               cpu_wr,
   output logic [chroni_pkg::mem_addr_w-1:0] mem_addr,
   output logic                              mem_rd_req,
   input  logic                              mem_rd_ack,
   input  logic [7:0]                        mem_data,
   output chroni_pkg::video_sync_t           sync,
   output chroni_pkg::rgb565_t               rgb
);
   import chroni_pkg::*;

   pal_wr_t     pal_wr;
   glyph_wr_t   glyph_wr;
   video_sync_t sync_raw;
   video_sync_t sync_d1;
   rgb565_t     pal_rgb;
   logic [7:0]  fg_index;
   logic [7:0]  bg_index;
   logic [7:0]  pix_index;
   logic [7:0]  rd_col;
   logic [5:0]  render_line;
   logic        frame_start;
   logic        render_start;
   logic        render_bank;
   logic        rd_bank;
   logic        wr_busy;

   chroni_regs u_regs (
      .sys_clk(sys_clk), .reset(reset), .cpu_wr(cpu_wr), .pal_wr(pal_wr),
      .fg_index(fg_index), .bg_index(bg_index)
   );

   video_timing u_timing (
      .sys_clk(sys_clk), .reset(reset), .sync(sync_raw), .frame_start(frame_start),
      .render_start(render_start), .render_line(render_line),
      .render_bank(render_bank), .rd_bank(rd_bank), .rd_col(rd_col)
   );

   char_gen u_char_gen (
      .sys_clk(sys_clk), .reset(reset), .frame_start(frame_start),
      .render_start(render_start), .render_line(render_line),
      .render_bank(render_bank), .fg_index(fg_index), .bg_index(bg_index),
      .mem_addr(mem_addr), .mem_rd_req(mem_rd_req), .mem_rd_ack(mem_rd_ack),
      .mem_data(mem_data), .glyph_wr(glyph_wr), .wr_busy(wr_busy)
   );

   line_buffer u_line_buffer (
      .sys_clk(sys_clk), .reset(reset), .glyph_wr(glyph_wr), .wr_busy(wr_busy),
      .rd_bank(rd_bank), .rd_col(rd_col), .rd_index(pix_index)
   );

   palette_lut u_palette (
      .sys_clk(sys_clk), .pal_wr(pal_wr), .rd_index(pix_index), .rgb(pal_rgb)
   );

   // Line buffer and palette each add a cycle.
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         sync_d1 <= '0;
         sync    <= '0;
      end else begin
         sync_d1 <= sync_raw;
         sync    <= sync_d1;
      end
   end

   assign rgb = sync.de ? pal_rgb : '0;

endmodule

/* hdl/chroni_regs.sv */
`timescale 1ns/1ps

module chroni_regs (
   input  logic                sys_clk,
   input  logic                reset,
   input  chroni_pkg::reg_wr_t cpu_wr,
   output chroni_pkg::pal_wr_t pal_wr,
   output logic [7:0]          fg_index,
   output logic [7:0]          bg_index
);
   import chroni_pkg::*;

   typedef enum logic [1:0] {
      st_low,
      st_high,
      st_commit
   } pal_state_t;

   pal_state_t pal_state;
   logic [7:0] pal_index;
   logic [7:0] colour_lo;
   logic [7:0] colour_hi;

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         pal_state <= st_low;
         pal_index <= '0;
         fg_index  <= '0;
         bg_index  <= '0;
      end else begin
         // Auto-increment after each committed entry.
         if (pal_state == st_commit) begin
            pal_index <= pal_index + 8'd1;
            pal_state <= st_low;
         end
         if (cpu_wr.en) begin
            case (cpu_wr.addr)
               reg_fg:        fg_index <= cpu_wr.data;
               reg_bg:        bg_index <= cpu_wr.data;
               reg_pal_index: begin
                  pal_index <= cpu_wr.data;
                  pal_state <= st_low;
               end
               reg_pal_data:  pal_state <= (pal_state == st_high) ? st_commit : st_high;
               default:       ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (cpu_wr.en && cpu_wr.addr == reg_pal_data) begin
         if (pal_state == st_high) begin
            colour_hi <= cpu_wr.data;
         end else begin
            colour_lo <= cpu_wr.data;
         end
      end
   end

   assign pal_wr = '{en: pal_state == st_commit, index: pal_index,
                     colour: {colour_hi, colour_lo}};

endmodule

/* hdl/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
   input  logic                  sys_clk,
   input  logic                  reset,
   input  chroni_pkg::glyph_wr_t glyph_wr,
   output logic                  wr_busy,
   input  logic                  rd_bank,
   input  logic [7:0]            rd_col,
   output logic [7:0]            rd_index
);
   import chroni_pkg::*;

   logic [7:0]                   buf_mem [2*h_active];
   logic [3:0]                   wr_cnt;
   logic [7:0]                   wr_bits;
   logic [7:0]                   wr_fg;
   logic [7:0]                   wr_bg;
   logic                         wr_bank;
   logic [$clog2(h_active)-1:0]  wr_pos;

   assign wr_busy = (wr_cnt != 4'd0);

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         wr_cnt <= '0;
      end else if (glyph_wr.en && !wr_busy) begin
         wr_cnt <= 4'(glyph_h);
      end else if (wr_busy) begin
         wr_cnt <= wr_cnt - 4'd1;
      end
   end

   // One pixel per cycle, MSB is the leftmost pixel.
   always_ff @(posedge sys_clk) begin
      if (glyph_wr.en && !wr_busy) begin
         wr_bits <= glyph_wr.bits;
         wr_fg   <= glyph_wr.fg;
         wr_bg   <= glyph_wr.bg;
         wr_bank <= glyph_wr.bank;
         wr_pos  <= glyph_wr.col_base[$clog2(h_active)-1:0];
      end else if (wr_busy) begin
         buf_mem[{wr_bank, wr_pos}] <= wr_bits[7] ? wr_fg : wr_bg;
         wr_bits <= {wr_bits[6:0], 1'b0};
         wr_pos  <= wr_pos + 1'b1;
      end
   end

   always_ff @(posedge sys_clk) begin
      rd_index <= buf_mem[{rd_bank, rd_col[$clog2(h_active)-1:0]}];
   end

endmodule

/* hdl/palette_lut.sv */
`timescale 1ns/1ps

module palette_lut (
   input  logic                sys_clk,
   input  chroni_pkg::pal_wr_t pal_wr,
   input  logic [7:0]          rd_index,
   output chroni_pkg::rgb565_t rgb
);

   logic [15:0] pal_mem [256];
   logic [15:0] rd_word;

   always_ff @(posedge sys_clk) begin
      if (pal_wr.en) begin
         pal_mem[pal_wr.index] <= pal_wr.colour;
      end
   end

   always_ff @(posedge sys_clk) begin
      rd_word <= pal_mem[rd_index];
   end

   // RGB565 layout, red in the top bits.
   always_comb begin
      rgb.r = rd_word[15:11];
      rgb.g = rd_word[10:5];
      rgb.b = rd_word[4:0];
   end

endmodule

/* verif/chroni_props.sv */
`timescale 1ns/1ps

module chroni_props (
   input logic                              sys_clk,
   input logic                              reset,
   input logic [chroni_pkg::mem_addr_w-1:0] mem_addr,
   input logic                              mem_rd_req,
   input logic                              mem_rd_ack,
   input chroni_pkg::video_sync_t           sync,
   input chroni_pkg::rgb565_t               rgb
);

   int unsigned fail_count = 0;

   // Request holds with a stable address until the acknowledge.
   assert property (@(posedge sys_clk) disable iff (reset)
      mem_rd_req && !mem_rd_ack |=> mem_rd_req && $stable(mem_addr))
      else begin
         $error("mem_rd_req dropped or mem_addr moved before mem_rd_ack");
         fail_count++;
      end

   assert property (@(posedge sys_clk) disable iff (reset)
      mem_rd_req && mem_rd_ack |=> !mem_rd_req)
      else begin
         $error("mem_rd_req still high the cycle after mem_rd_ack");
         fail_count++;
      end

   assert property (@(posedge sys_clk) disable iff (reset)
      !(sync.de && (sync.hs || sync.vs)))
      else begin
         $error("de high during hs or vs");
         fail_count++;
      end

   assert property (@(posedge sys_clk) disable iff (reset)
      !sync.de |-> rgb == '0)
      else begin
         $error("rgb not blanked while de is low");
         fail_count++;
      end

endmodule

bind chroni chroni_props u_props (
   .sys_clk(sys_clk), .reset(reset), .mem_addr(mem_addr), .mem_rd_req(mem_rd_req),
   .mem_rd_ack(mem_rd_ack), .sync(sync), .rgb(rgb)
);

/* verif/chroni_tb.sv */
`timescale 1ns/1ps

module chroni_tb;
   import chroni_pkg::*;

   localparam int frame_cycles   = h_total * v_total;
   // About three frames per settled frame check, twenty frames in all.
   localparam int timeout_cycles = 20 * frame_cycles;

   logic                  sys_clk;
   logic                  reset;
   reg_wr_t               cpu_wr;
   logic [mem_addr_w-1:0] mem_addr;
   logic                  mem_rd_req;
   logic                  mem_rd_ack = 1'b0;
   logic [7:0]            mem_data = 8'h00;
   video_sync_t           sync;
   rgb565_t               rgb;

   logic [7:0]  mem [2**mem_addr_w];
   logic [15:0] pal_model [256];
   logic [7:0]  fg_model;
   logic [7:0]  bg_model;
   logic [7:0]  pal_idx;
   logic [7:0]  pal_lo;
   logic        pal_hi;
   logic        rand_lat = 1'b0;
   integer      seed = 92;
   int          wait_left;
   bit          pending;
   int          cycles;

   chroni uut (
      .sys_clk(sys_clk), .reset(reset), .cpu_wr(cpu_wr), .mem_addr(mem_addr),
      .mem_rd_req(mem_rd_req), .mem_rd_ack(mem_rd_ack), .mem_data(mem_data),
      .sync(sync), .rgb(rgb)
   );

   initial begin
      sys_clk = 1'b0;
      forever #5 sys_clk = ~sys_clk;
   end

   always @(posedge sys_clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Timeout after %0d cycles, a test did not finish.", cycles);
         $display("Simulation failed");
         $fatal(1, "Run stopped by the cycle limit.");
      end
   end

   always @(negedge sys_clk) begin
      if (uut.u_props.fail_count != 0) begin
         $display("A bound assertion on the memory port or the video outputs failed.");
         $display("Simulation failed");
         $fatal(1, "Stopped at the first assertion failure.");
      end
   end

   // Memory model. One cycle of latency, or 0 to 7 in random mode.
   always @(negedge sys_clk) begin
      if (mem_rd_ack) begin
         mem_rd_ack = 1'b0;
         pending    = 1'b0;
      end else if (mem_rd_req === 1'b1) begin
         if (!pending) begin
            pending   = 1'b1;
            wait_left = rand_lat ? $unsigned($random(seed)) % 8 : 1;
         end
         if (wait_left == 0) begin
            mem_rd_ack = 1'b1;
            mem_data   = mem[mem_addr];
         end else begin
            wait_left--;
         end
      end else begin
         pending = 1'b0;
      end
   end

   task automatic stop_on_error();
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error.");
   endtask

   task automatic check_rgb(string name, rgb565_t exp, rgb565_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (act != exp) begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         stop_on_error();
      end
   endtask

   // One CPU strobe, mirrored into the register model.
   task automatic reg_write(logic [3:0] reg_addr, logic [7:0] reg_data);
      @(negedge sys_clk);
      cpu_wr = '{en: 1'b1, addr: reg_addr, data: reg_data};
      @(negedge sys_clk);
      cpu_wr = '0;
      case (reg_addr)
         reg_fg: fg_model = reg_data;
         reg_bg: bg_model = reg_data;
         reg_pal_index: begin
            pal_idx = reg_data;
            pal_hi  = 1'b0;
         end
         reg_pal_data: begin
            if (pal_hi) begin
               pal_model[pal_idx] = {reg_data, pal_lo};
               pal_idx = pal_idx + 8'd1;
               pal_hi  = 1'b0;
            end else begin
               pal_lo = reg_data;
               pal_hi = 1'b1;
            end
         end
         default: ;
      endcase
   endtask

   task automatic pal_write(logic [7:0] index, logic [15:0] colour);
      reg_write(reg_pal_index, index);
      reg_write(reg_pal_data, colour[7:0]);
      reg_write(reg_pal_data, colour[15:8]);
   endtask

   // Returns on the first sample where vs has just changed to level.
   task automatic wait_vs_edge(logic level);
      logic prev;
      prev = sync.vs;
      @(negedge sys_clk);
      while (!(sync.vs == level && prev != level)) begin
         prev = sync.vs;
         @(negedge sys_clk);
      end
   endtask

   task automatic settle();
      wait_vs_edge(1'b1);
      wait_vs_edge(1'b1);
   endtask

   function automatic rgb565_t expected_pixel(int x, int y);
      logic [7:0]  code;
      logic [7:0]  font;
      logic [15:0] word;
      code = mem[text_base + (y / glyph_h) * text_cols + x / 8];
      font = mem[font_base + code * 8 + y % glyph_h];
      word = font[7 - x % 8] ? pal_model[fg_model] : pal_model[bg_model];
      return '{r: word[15:11], g: word[10:5], b: word[4:0]};
   endfunction

   // Follows de from the end of vs through all visible lines.
   task automatic check_frame(string name);
      int   x;
      int   y;
      logic prev_de;
      x       = 0;
      y       = 0;
      prev_de = 1'b0;
      wait_vs_edge(1'b0);
      while (y < v_active) begin
         @(negedge sys_clk);
         if (sync.de) begin
            check_rgb($sformatf("%s x=%0d y=%0d", name, x, y), expected_pixel(x, y), rgb);
            x++;
         end else if (prev_de) begin
            x = 0;
            y++;
         end
         prev_de = sync.de;
      end
   endtask

   task automatic test_sync_counts();
      int          hs_cnt = 0;
      int          vs_cnt = 0;
      int          vs_cycles = 0;
      int          de_cycles = 0;
      video_sync_t prev;
      prev = '0;
      wait_vs_edge(1'b1);
      repeat (frame_cycles) begin
         if (sync.hs && !prev.hs) hs_cnt++;
         if (sync.vs && !prev.vs) vs_cnt++;
         if (sync.vs) vs_cycles++;
         if (sync.de) de_cycles++;
         prev = sync;
         @(negedge sys_clk);
      end
      check_count("sync_counts hs pulses", v_total, hs_cnt);
      check_count("sync_counts vs pulses", 1, vs_cnt);
      check_count("sync_counts vs cycles", vs_len * h_total, vs_cycles);
      check_count("sync_counts de cycles", h_active * v_active, de_cycles);
   endtask

   task automatic test_text();
      pal_write(8'h01, 16'hf81f);
      pal_write(8'h02, 16'h07e0);
      reg_write(reg_fg, 8'h01);
      reg_write(reg_bg, 8'h02);
      settle();
      check_frame("text");
   endtask

   task automatic test_pal_autoinc();
      reg_write(reg_pal_index, 8'h40);
      reg_write(reg_pal_data, 8'h1f);
      reg_write(reg_pal_data, 8'h00);
      reg_write(reg_pal_data, 8'he0);
      reg_write(reg_pal_data, 8'hff);
      reg_write(reg_pal_data, 8'h10);
      reg_write(reg_pal_data, 8'h84);
      reg_write(reg_fg, 8'h42);
      reg_write(reg_bg, 8'h40);
      settle();
      check_frame("pal_autoinc");
   endtask

   // Index write between the two bytes drops the pending low byte.
   task automatic test_pal_restart();
      reg_write(reg_pal_index, 8'h80);
      reg_write(reg_pal_data, 8'haa);
      reg_write(reg_pal_index, 8'h81);
      reg_write(reg_pal_data, 8'h34);
      reg_write(reg_pal_data, 8'h12);
      reg_write(reg_fg, 8'h81);
      settle();
      check_frame("pal_restart");
   endtask

   task automatic test_mem_latency();
      int i;
      rand_lat = 1'b1;
      for (i = 0; i < text_cols * text_rows; i++) begin
         mem[text_base + i] = 8'($random(seed));
      end
      settle();
      check_frame("mem_latency");
   endtask

   initial begin
      int i;
      reset    = 1'b1;
      cpu_wr   = '0;
      fg_model = 8'h00;
      bg_model = 8'h00;
      pal_idx  = 8'h00;
      pal_lo   = 8'h00;
      pal_hi   = 1'b0;
      for (i = 0; i < 2**mem_addr_w; i++) begin
         mem[i] = 8'((i * 37) ^ (i >> 5));
      end
      repeat (5) @(negedge sys_clk);
      reset = 1'b0;
      test_sync_counts();
      test_text();
      test_pal_autoinc();
      test_pal_restart();
      test_mem_latency();
      $display("Simulation passed");
      $finish;
   end

endmodule

/* video_timing/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
   input  logic                    sys_clk,
   input  logic                    reset,
   output chroni_pkg::video_sync_t sync,
   output logic                    frame_start,
   output logic                    render_start,
   output logic [5:0]              render_line,
   output logic                    render_bank,
   output logic                    rd_bank,
   output logic [7:0]              rd_col
);
   import chroni_pkg::*;

   logic [9:0] h_cnt;
   logic [5:0] v_cnt;
   logic       h_last;
   logic       v_last;
   logic [5:0] next_line;

   assign h_last    = (h_cnt == 10'(h_total - 1));
   assign v_last    = (v_cnt == 6'(v_total - 1));
   assign next_line = v_last ? 6'd0 : v_cnt + 6'd1;

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_last) begin
         h_cnt <= '0;
         v_cnt <= v_last ? 6'd0 : v_cnt + 6'd1;
      end else begin
         h_cnt <= h_cnt + 10'd1;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         sync         <= '0;
         frame_start  <= 1'b0;
         render_start <= 1'b0;
      end else begin
         sync.hs <= (h_cnt >= 10'(hs_start)) && (h_cnt < 10'(hs_start + hs_len));
         sync.vs <= (v_cnt >= 6'(vs_start)) && (v_cnt < 6'(vs_start + vs_len));
         sync.de <= (h_cnt < 10'(h_active)) && (v_cnt < 6'(v_active));
         // Render one line ahead, so the last blank line prepares line 0.
         render_start <= (h_cnt == 10'd0) && (v_last || v_cnt < 6'(v_active - 1));
         frame_start  <= (h_cnt == 10'd0) && v_last;
      end
   end

   always_ff @(posedge sys_clk) begin
      rd_col      <= h_cnt[7:0];
      rd_bank     <= v_cnt[0];
      render_line <= next_line;
      render_bank <= next_line[0];
   end

endmodule
